// File: source/x86_isa_pkg.sv
`default_nettype none

package x86_isa_pkg;

  // Fetch window and field widths
  localparam int WINDOW_BYTES = 16;
  localparam int MAX_PREFIXES = 4;
  localparam int NUM_SEGS     = 6;
  localparam int EIP_W        = 32;
  localparam int LEN_W        = 4;
  localparam int CNT_W        = 3;
  localparam int REG_W        = 3;
  localparam int FLAG_W       = 6;

  localparam logic [REG_W-1:0] REG_EAX = 3'd0;

  // Prefix byte values
  localparam logic [7:0] PFX_OPSIZE = 8'h66;
  localparam logic [7:0] PFX_REPNE  = 8'hF2;
  localparam logic [7:0] PFX_ES     = 8'h26;
  localparam logic [7:0] PFX_CS     = 8'h2E;
  localparam logic [7:0] PFX_SS     = 8'h36;
  localparam logic [7:0] PFX_DS     = 8'h3E;
  localparam logic [7:0] PFX_FS     = 8'h64;
  localparam logic [7:0] PFX_GS     = 8'h65;

  // Override bytes indexed by segment number
  localparam logic [NUM_SEGS-1:0][7:0] SEG_PFX = {
    PFX_GS, PFX_FS, PFX_DS, PFX_SS, PFX_CS, PFX_ES
  };

  // Flag load mask, OF in the top bit down to CF
  localparam logic [FLAG_W-1:0] FLAGS_NONE  = 6'b00_0000;
  localparam logic [FLAG_W-1:0] FLAGS_ARITH = 6'b11_1111;

  typedef enum logic [3:0] {
    add_rm_r,
    add_r_rm,
    add_eax_imm,
    mov_rm_r,
    mov_r_rm,
    mov_r_imm,
    jmp_rel32,
    jmp_rel8,
    nop,
    hlt,
    illegal
  } opcode_e;

  typedef enum logic [1:0] {
    pass_b,
    add,
    add_eip
  } alu_op_e;

  typedef enum logic [2:0] {
    seg_es,
    seg_cs,
    seg_ss,
    seg_ds,
    seg_fs,
    seg_gs
  } seg_reg_e;

endpackage

`default_nettype wire

// File: source/decode_pkg.sv
`default_nettype none

package decode_pkg;

  typedef enum logic [1:0] {
    imm_none,
    imm8,
    immv
  } imm_kind_e;

  // Where a register operand comes from
  typedef enum logic [2:0] {
    role_none,
    role_reg,
    role_rm,
    role_eax,
    role_opreg
  } role_e;

  typedef struct packed {
    logic [x86_isa_pkg::WINDOW_BYTES-1:0][7:0] window;
    logic [x86_isa_pkg::EIP_W-1:0]             eip;
  } fetch_bundle_t;

  typedef struct packed {
    logic [x86_isa_pkg::CNT_W-1:0] count;
    logic                          op_size_over;
    logic                          repne;
    logic                          seg_over;
    x86_isa_pkg::seg_reg_e         seg;
  } prefix_info_t;

  typedef struct packed {
    logic [2:0] size;
    logic       sib_present;
    logic [2:0] disp_bytes;
    logic       is_mem;
  } modrm_fmt_t;

  typedef struct packed {
    x86_isa_pkg::opcode_e           op;
    x86_isa_pkg::alu_op_e           alu_op;
    logic                           has_modrm;
    logic                           reg_in_opcode;
    imm_kind_e                      imm_kind;
    // Immediate bytes after the operand size is applied
    logic [2:0]                     imm_bytes;
    role_e                          src1;
    role_e                          src2;
    role_e                          dst;
    logic [x86_isa_pkg::FLAG_W-1:0] ld_flags;
    logic                           illegal;
  } ctrl_word_t;

  typedef struct packed {
    logic [x86_isa_pkg::EIP_W-1:0]  eip;
    logic [x86_isa_pkg::EIP_W-1:0]  next_eip;
    logic [x86_isa_pkg::LEN_W-1:0]  length;
    prefix_info_t                   prefix;
    x86_isa_pkg::opcode_e           op;
    x86_isa_pkg::alu_op_e           alu_op;
    logic [x86_isa_pkg::REG_W-1:0]  src1;
    logic                           src1_needed;
    logic [x86_isa_pkg::REG_W-1:0]  src2;
    logic                           src2_needed;
    logic [x86_isa_pkg::REG_W-1:0]  dst;
    logic                           ld_reg;
    logic                           mem_read;
    logic                           mem_write;
    logic [1:0]                     scale;
    logic [x86_isa_pkg::REG_W-1:0]  index;
    logic [x86_isa_pkg::REG_W-1:0]  base;
    logic                           sib_present;
    logic [31:0]                    disp32;
    logic [31:0]                    imm32;
    logic [x86_isa_pkg::FLAG_W-1:0] ld_flags;
    logic                           illegal;
  } decode_bundle_t;

endpackage

`default_nettype wire

// File: source/prefix_scanner.sv
`default_nettype none

module prefix_scanner (
  input  logic [x86_isa_pkg::WINDOW_BYTES-1:0][7:0] window,
  output decode_pkg::prefix_info_t                 info
);

  logic [x86_isa_pkg::MAX_PREFIXES-1:0] is_pfx;
  logic [x86_isa_pkg::MAX_PREFIXES-1:0] in_run;
  logic [x86_isa_pkg::NUM_SEGS-1:0]     seg_hit;

  // Any known prefix value in the leading bytes
  always_comb begin
    for (int i = 0; i < x86_isa_pkg::MAX_PREFIXES; i++) begin
      is_pfx[i] = (window[i] == x86_isa_pkg::PFX_OPSIZE) ||
                  (window[i] == x86_isa_pkg::PFX_REPNE);
      for (int s = 0; s < x86_isa_pkg::NUM_SEGS; s++) begin
        if (window[i] == x86_isa_pkg::SEG_PFX[s]) begin
          is_pfx[i] = 1'b1;
        end
      end
    end
  end

  // Thermometer of the unbroken run from byte 0
  always_comb begin
    in_run[0] = is_pfx[0];
    for (int i = 1; i < x86_isa_pkg::MAX_PREFIXES; i++) begin
      in_run[i] = in_run[i-1] & is_pfx[i];
    end
  end

  always_comb begin
    info    = '0;
    seg_hit = '0;
    for (int i = 0; i < x86_isa_pkg::MAX_PREFIXES; i++) begin
      if (in_run[i]) begin
        info.count = info.count + 3'd1;
        if (window[i] == x86_isa_pkg::PFX_OPSIZE) begin
          info.op_size_over = 1'b1;
        end
        if (window[i] == x86_isa_pkg::PFX_REPNE) begin
          info.repne = 1'b1;
        end
        for (int s = 0; s < x86_isa_pkg::NUM_SEGS; s++) begin
          seg_hit[s] = seg_hit[s] | (window[i] == x86_isa_pkg::SEG_PFX[s]);
        end
      end
    end
    info.seg_over = |seg_hit;
    // Lowest segment number wins
    for (int s = x86_isa_pkg::NUM_SEGS - 1; s >= 0; s--) begin
      if (seg_hit[s]) begin
        info.seg = x86_isa_pkg::seg_reg_e'(s);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/opcode_rom.sv
`default_nettype none

module opcode_rom (
  input  logic [7:0]             opcode,
  input  logic                   op_size_over,
  output decode_pkg::ctrl_word_t ctrl
);

  always_comb begin
    ctrl          = '0;
    ctrl.op       = x86_isa_pkg::illegal;
    ctrl.ld_flags = x86_isa_pkg::FLAGS_NONE;
    ctrl.illegal  = 1'b1;
    casez (opcode)
      8'h01: begin
        ctrl.op        = x86_isa_pkg::add_rm_r;
        ctrl.alu_op    = x86_isa_pkg::add;
        ctrl.has_modrm = 1'b1;
        ctrl.src1      = decode_pkg::role_rm;
        ctrl.src2      = decode_pkg::role_reg;
        ctrl.dst       = decode_pkg::role_rm;
        ctrl.ld_flags  = x86_isa_pkg::FLAGS_ARITH;
      end
      8'h03: begin
        ctrl.op        = x86_isa_pkg::add_r_rm;
        ctrl.alu_op    = x86_isa_pkg::add;
        ctrl.has_modrm = 1'b1;
        ctrl.src1      = decode_pkg::role_reg;
        ctrl.src2      = decode_pkg::role_rm;
        ctrl.dst       = decode_pkg::role_reg;
        ctrl.ld_flags  = x86_isa_pkg::FLAGS_ARITH;
      end
      8'h05: begin
        ctrl.op       = x86_isa_pkg::add_eax_imm;
        ctrl.alu_op   = x86_isa_pkg::add;
        ctrl.imm_kind = decode_pkg::immv;
        ctrl.src1     = decode_pkg::role_eax;
        ctrl.dst      = decode_pkg::role_eax;
        ctrl.ld_flags = x86_isa_pkg::FLAGS_ARITH;
      end
      // Moves pass operand B straight through
      8'h89: begin
        ctrl.op        = x86_isa_pkg::mov_rm_r;
        ctrl.has_modrm = 1'b1;
        ctrl.src2      = decode_pkg::role_reg;
        ctrl.dst       = decode_pkg::role_rm;
      end
      8'h8B: begin
        ctrl.op        = x86_isa_pkg::mov_r_rm;
        ctrl.has_modrm = 1'b1;
        ctrl.src2      = decode_pkg::role_rm;
        ctrl.dst       = decode_pkg::role_reg;
      end
      8'b1011_1???: begin
        ctrl.op            = x86_isa_pkg::mov_r_imm;
        ctrl.reg_in_opcode = 1'b1;
        ctrl.imm_kind      = decode_pkg::immv;
        ctrl.dst           = decode_pkg::role_opreg;
      end
      8'hE9: begin
        ctrl.op       = x86_isa_pkg::jmp_rel32;
        ctrl.alu_op   = x86_isa_pkg::add_eip;
        ctrl.imm_kind = decode_pkg::immv;
      end
      8'hEB: begin
        ctrl.op       = x86_isa_pkg::jmp_rel8;
        ctrl.alu_op   = x86_isa_pkg::add_eip;
        ctrl.imm_kind = decode_pkg::imm8;
      end
      8'h90: ctrl.op = x86_isa_pkg::nop;
      8'hF4: ctrl.op = x86_isa_pkg::hlt;
      default: ;
    endcase
    if (ctrl.op != x86_isa_pkg::illegal) begin
      ctrl.illegal = 1'b0;
    end
    // Full size immediate shrinks to a word under 66
    case (ctrl.imm_kind)
      decode_pkg::imm8: ctrl.imm_bytes = 3'd1;
      decode_pkg::immv: ctrl.imm_bytes = op_size_over ? 3'd2 : 3'd4;
      default:          ctrl.imm_bytes = 3'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/modrm_decoder.sv
`default_nettype none

module modrm_decoder (
  input  logic [7:0]             modrm,
  output decode_pkg::modrm_fmt_t fmt
);

  logic [1:0] mod_f;
  logic [2:0] rm_f;
  logic       rm_sib;

  assign mod_f  = modrm[7:6];
  assign rm_f   = modrm[2:0];
  assign rm_sib = (rm_f == 3'b100);

  always_comb begin
    fmt             = '0;
    fmt.is_mem      = (mod_f != 2'b11);
    fmt.sib_present = fmt.is_mem && rm_sib;
    case (mod_f)
      2'b00: begin
        if (rm_f == 3'b101) begin
          // Absolute disp32 with no base
          fmt.size       = 3'd5;
          fmt.disp_bytes = 3'd4;
        end else begin
          fmt.size = rm_sib ? 3'd2 : 3'd1;
        end
      end
      2'b01: begin
        fmt.size       = rm_sib ? 3'd3 : 3'd2;
        fmt.disp_bytes = 3'd1;
      end
      2'b10: begin
        fmt.size       = rm_sib ? 3'd6 : 3'd5;
        fmt.disp_bytes = 3'd4;
      end
      default: fmt.size = 3'd1;
    endcase
  end

endmodule

`default_nettype wire

// File: source/field_extractor.sv
`default_nettype none

module field_extractor (
  input  decode_pkg::fetch_bundle_t  fetch,
  input  decode_pkg::prefix_info_t   info,
  input  decode_pkg::ctrl_word_t     ctrl,
  input  decode_pkg::modrm_fmt_t     fmt,
  output logic [7:0]                 opcode,
  output logic [7:0]                 modrm,
  output decode_pkg::decode_bundle_t dec
);

  logic [x86_isa_pkg::WINDOW_BYTES*8-1:0] win;
  logic [x86_isa_pkg::LEN_W-1:0]          op_pos;
  logic [x86_isa_pkg::LEN_W-1:0]          disp_pos;
  logic [x86_isa_pkg::LEN_W-1:0]          imm_pos;
  logic [x86_isa_pkg::LEN_W-1:0]          len;
  logic [2:0]                             modrm_size;
  logic                                   sib_present;
  logic [7:0]                             sib;
  logic [31:0]                            disp_raw;
  logic [31:0]                            imm_raw;

  function automatic logic [x86_isa_pkg::REG_W-1:0] role_index(
    decode_pkg::role_e role, logic [7:0] op_byte, logic [7:0] mrm);
    case (role)
      decode_pkg::role_reg:   return mrm[5:3];
      decode_pkg::role_rm:    return mrm[2:0];
      decode_pkg::role_eax:   return x86_isa_pkg::REG_EAX;
      decode_pkg::role_opreg: return op_byte[2:0];
      default:                return '0;
    endcase
  endfunction

  // A role is live unless it names a memory rm
  function automatic logic role_live(decode_pkg::role_e role, logic is_mem);
    return (role != decode_pkg::role_none) && !((role == decode_pkg::role_rm) && is_mem);
  endfunction

  assign win         = fetch.window;
  assign op_pos      = x86_isa_pkg::LEN_W'(info.count);
  assign opcode      = win[{op_pos, 3'b000} +: 8];
  assign modrm       = win[{op_pos + 4'd1, 3'b000} +: 8];
  assign modrm_size  = ctrl.has_modrm ? fmt.size : 3'd0;
  assign sib_present = ctrl.has_modrm & fmt.sib_present;
  assign sib         = sib_present ? win[{op_pos + 4'd2, 3'b000} +: 8] : 8'h00;
  assign disp_pos    = op_pos + 4'd2 + {3'b000, sib_present};
  assign imm_pos     = op_pos + 4'd1 + {1'b0, modrm_size};
  assign disp_raw    = win[{disp_pos, 3'b000} +: 32];
  assign imm_raw     = win[{imm_pos, 3'b000} +: 32];
  assign len         = imm_pos + x86_isa_pkg::LEN_W'(ctrl.imm_bytes);

  always_comb begin
    dec             = '0;
    dec.eip         = fetch.eip;
    dec.length      = len;
    dec.next_eip    = fetch.eip + x86_isa_pkg::EIP_W'(len);
    dec.prefix      = info;
    dec.op          = ctrl.op;
    dec.alu_op      = ctrl.alu_op;
    dec.ld_flags    = ctrl.ld_flags;
    dec.illegal     = ctrl.illegal;
    dec.src1        = role_index(ctrl.src1, opcode, modrm);
    dec.src2        = role_index(ctrl.src2, opcode, modrm);
    dec.dst         = role_index(ctrl.dst, opcode, modrm);
    dec.src1_needed = role_live(ctrl.src1, fmt.is_mem);
    dec.src2_needed = role_live(ctrl.src2, fmt.is_mem);
    dec.ld_reg      = role_live(ctrl.dst, fmt.is_mem);
    dec.mem_read    = fmt.is_mem && ((ctrl.src1 == decode_pkg::role_rm) ||
                                     (ctrl.src2 == decode_pkg::role_rm));
    dec.mem_write   = fmt.is_mem && (ctrl.dst == decode_pkg::role_rm);
    dec.scale       = sib[7:6];
    dec.index       = sib[5:3];
    dec.base        = sib[2:0];
    dec.sib_present = sib_present;
    case (ctrl.has_modrm ? fmt.disp_bytes : 3'd0)
      3'd1:    dec.disp32 = {{24{disp_raw[7]}}, disp_raw[7:0]};
      3'd4:    dec.disp32 = disp_raw;
      default: dec.disp32 = '0;
    endcase
    case (ctrl.imm_bytes)
      3'd1:    dec.imm32 = {{24{imm_raw[7]}}, imm_raw[7:0]};
      3'd2:    dec.imm32 = {{16{imm_raw[15]}}, imm_raw[15:0]};
      3'd4:    dec.imm32 = imm_raw;
      default: dec.imm32 = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`default_nettype none

module decode_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  decode_pkg::fetch_bundle_t  fetch,
  input  logic                       fetch_valid,
  output logic                       fetch_ready,
  output decode_pkg::decode_bundle_t dec,
  output logic                       dec_valid,
  input  logic                       dec_ready
);

  decode_pkg::prefix_info_t   info;
  decode_pkg::ctrl_word_t     ctrl;
  decode_pkg::modrm_fmt_t     fmt;
  decode_pkg::decode_bundle_t dec_next;
  logic [7:0]                 opcode;
  logic [7:0]                 modrm;
  logic                       accept;

  prefix_scanner i_prefix_scanner (
    .window (fetch.window),
    .info   (info)
  );

  // Opcode control table
  opcode_rom i_opcode_rom (
    .opcode       (opcode),
    .op_size_over (info.op_size_over),
    .ctrl         (ctrl)
  );

  // ModRM format table
  modrm_decoder i_modrm_decoder (
    .modrm (modrm),
    .fmt   (fmt)
  );

  field_extractor i_field_extractor (
    .fetch  (fetch),
    .info   (info),
    .ctrl   (ctrl),
    .fmt    (fmt),
    .opcode (opcode),
    .modrm  (modrm),
    .dec    (dec_next)
  );

  // Register refills on the same edge it drains
  assign fetch_ready = !dec_valid || dec_ready;
  assign accept      = fetch_valid && fetch_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (fetch_ready) begin
      dec_valid <= fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec <= dec_next;
    end
  end

endmodule

`default_nettype wire

// File: sim/decode_checker.sv
`default_nettype none

module decode_checker (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       fetch_valid,
  input logic                       fetch_ready,
  input logic                       dec_valid,
  input logic                       dec_ready,
  input decode_pkg::decode_bundle_t dec
);

  // Register comes out of reset empty and open for input
  reset_idle: assert property (@(posedge clk) !rst_n |=> !dec_valid && fetch_ready)
    else $error("Decode stage not idle after reset");

  ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_ready == (!dec_valid || dec_ready))
    else $error("fetch_ready does not follow dec_valid and dec_ready");

  // One cycle from accepted input to valid output
  fill_latency: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid && fetch_ready |=> dec_valid)
    else $error("dec_valid missing one cycle after an accepted input");

  drain_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !fetch_valid && fetch_ready |=> !dec_valid)
    else $error("dec_valid high with no input accepted");

  // Back-pressure holds the bundle
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid && !dec_ready |=> dec_valid && $stable(dec))
    else $error("Decoded bundle changed while stalled");

endmodule

bind decode_stage decode_checker i_decode_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .fetch_valid (fetch_valid),
  .fetch_ready (fetch_ready),
  .dec_valid   (dec_valid),
  .dec_ready   (dec_ready),
  .dec         (dec)
);

`default_nettype wire

// File: sim/tb_decode_stage.sv
`default_nettype none

module tb_decode_stage;

  localparam int NUM_INSTR = 400;

  logic                       clk;
  logic                       rst_n;
  decode_pkg::fetch_bundle_t  fetch;
  logic                       fetch_valid;
  logic                       fetch_ready;
  decode_pkg::decode_bundle_t dec;
  logic                       dec_valid;
  logic                       dec_ready;

  decode_pkg::decode_bundle_t exp_q[$];
  decode_pkg::decode_bundle_t exp_head;
  int                         exp_count = 0;
  int                         n_out = 0;
  int                         n_sent = 0;
  logic                       in_taken = 1'b0;

  decode_stage i_decode_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .dec         (dec),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Segment number of an override byte, -1 for anything else
  function automatic int seg_number(input logic [7:0] b);
    case (b)
      x86_isa_pkg::PFX_ES: return 0;
      x86_isa_pkg::PFX_CS: return 1;
      x86_isa_pkg::PFX_SS: return 2;
      x86_isa_pkg::PFX_DS: return 3;
      x86_isa_pkg::PFX_FS: return 4;
      x86_isa_pkg::PFX_GS: return 5;
      default:             return -1;
    endcase
  endfunction

  function automatic logic is_prefix(input logic [7:0] b);
    return (b == x86_isa_pkg::PFX_OPSIZE) || (b == x86_isa_pkg::PFX_REPNE) ||
           (seg_number(b) >= 0);
  endfunction

  // Little-endian field, sign-extended from its byte count
  function automatic logic [31:0] read_signed(input decode_pkg::fetch_bundle_t fb,
                                              input int pos, input int nbytes);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < nbytes; k++) begin
      v[8*k +: 8] = fb.window[pos + k];
    end
    if (nbytes == 1) begin
      v = {{24{v[7]}}, v[7:0]};
    end else if (nbytes == 2) begin
      v = {{16{v[15]}}, v[15:0]};
    end
    return v;
  endfunction

  function automatic decode_pkg::decode_bundle_t expected_bundle(
    input decode_pkg::fetch_bundle_t fb);
    decode_pkg::decode_bundle_t e;
    logic [7:0] op;
    logic [7:0] mrm;
    logic [2:0] reg_f;
    logic [2:0] rm_f;
    logic       mem;
    logic       has_modrm;
    int         cnt;
    int         seg_lo;
    int         mrm_size;
    int         disp_n;
    int         imm_n;
    int         imm_v;
    int         imm_pos;
    e      = '0;
    cnt    = 0;
    seg_lo = 6;
    while (cnt < x86_isa_pkg::MAX_PREFIXES && is_prefix(fb.window[cnt])) begin
      if (fb.window[cnt] == x86_isa_pkg::PFX_OPSIZE) e.prefix.op_size_over = 1'b1;
      if (fb.window[cnt] == x86_isa_pkg::PFX_REPNE) e.prefix.repne = 1'b1;
      if (seg_number(fb.window[cnt]) >= 0 && seg_number(fb.window[cnt]) < seg_lo) begin
        seg_lo = seg_number(fb.window[cnt]);
      end
      cnt++;
    end
    e.prefix.count = 3'(cnt);
    if (seg_lo < 6) begin
      e.prefix.seg_over = 1'b1;
      e.prefix.seg      = x86_isa_pkg::seg_reg_e'(3'(seg_lo));
    end
    op        = fb.window[cnt];
    mrm       = fb.window[cnt + 1];
    reg_f     = mrm[5:3];
    rm_f      = mrm[2:0];
    mem       = (mrm[7:6] != 2'b11);
    has_modrm = 1'b0;
    imm_n     = 0;
    imm_v     = e.prefix.op_size_over ? 2 : 4;
    e.eip     = fb.eip;
    e.op      = x86_isa_pkg::illegal;
    case (op)
      8'h01, 8'h03: begin
        has_modrm     = 1'b1;
        e.op          = (op == 8'h01) ? x86_isa_pkg::add_rm_r : x86_isa_pkg::add_r_rm;
        e.alu_op      = x86_isa_pkg::add;
        e.ld_flags    = 6'b111111;
        e.src1        = (op == 8'h01) ? rm_f : reg_f;
        e.src1_needed = (op == 8'h01) ? !mem : 1'b1;
        e.src2        = (op == 8'h01) ? reg_f : rm_f;
        e.src2_needed = (op == 8'h01) ? 1'b1 : !mem;
        e.dst         = (op == 8'h01) ? rm_f : reg_f;
        e.ld_reg      = (op == 8'h01) ? !mem : 1'b1;
        e.mem_read    = mem;
        e.mem_write   = (op == 8'h01) && mem;
      end
      8'h05: begin
        e.op          = x86_isa_pkg::add_eax_imm;
        e.alu_op      = x86_isa_pkg::add;
        e.ld_flags    = 6'b111111;
        imm_n         = imm_v;
        e.src1        = x86_isa_pkg::REG_EAX;
        e.src1_needed = 1'b1;
        e.dst         = x86_isa_pkg::REG_EAX;
        e.ld_reg      = 1'b1;
      end
      8'h89: begin
        has_modrm     = 1'b1;
        e.op          = x86_isa_pkg::mov_rm_r;
        e.src2        = reg_f;
        e.src2_needed = 1'b1;
        e.dst         = rm_f;
        e.ld_reg      = !mem;
        e.mem_write   = mem;
      end
      8'h8B: begin
        has_modrm     = 1'b1;
        e.op          = x86_isa_pkg::mov_r_rm;
        e.src2        = rm_f;
        e.src2_needed = !mem;
        e.dst         = reg_f;
        e.ld_reg      = 1'b1;
        e.mem_read    = mem;
      end
      8'hB8, 8'hB9, 8'hBA, 8'hBB, 8'hBC, 8'hBD, 8'hBE, 8'hBF: begin
        e.op     = x86_isa_pkg::mov_r_imm;
        imm_n    = imm_v;
        e.dst    = op[2:0];
        e.ld_reg = 1'b1;
      end
      8'hE9: begin
        e.op     = x86_isa_pkg::jmp_rel32;
        e.alu_op = x86_isa_pkg::add_eip;
        imm_n    = imm_v;
      end
      8'hEB: begin
        e.op     = x86_isa_pkg::jmp_rel8;
        e.alu_op = x86_isa_pkg::add_eip;
        imm_n    = 1;
      end
      8'h90: e.op = x86_isa_pkg::nop;
      8'hF4: e.op = x86_isa_pkg::hlt;
      default: ;
    endcase
    e.illegal = (e.op == x86_isa_pkg::illegal);
    mrm_size  = 0;
    disp_n    = 0;
    if (has_modrm) begin
      case (mrm[7:6])
        2'b00: begin
          if (rm_f == 3'd5) begin
            mrm_size = 5;
            disp_n   = 4;
          end else begin
            mrm_size = (rm_f == 3'd4) ? 2 : 1;
          end
        end
        2'b01: begin
          mrm_size = (rm_f == 3'd4) ? 3 : 2;
          disp_n   = 1;
        end
        2'b10: begin
          mrm_size = (rm_f == 3'd4) ? 6 : 5;
          disp_n   = 4;
        end
        default: mrm_size = 1;
      endcase
      e.sib_present = mem && (rm_f == 3'd4);
    end
    if (e.sib_present) begin
      {e.scale, e.index, e.base} = fb.window[cnt + 2];
    end
    e.disp32   = read_signed(fb, cnt + 2 + (e.sib_present ? 1 : 0), disp_n);
    imm_pos    = cnt + 1 + mrm_size;
    e.imm32    = read_signed(fb, imm_pos, imm_n);
    e.length   = 4'(imm_pos + imm_n);
    e.next_eip = fb.eip + 32'(imm_pos + imm_n);
    return e;
  endfunction

  function automatic logic [7:0] pick_prefix(input int k);
    case (k)
      0:       return x86_isa_pkg::PFX_OPSIZE;
      1:       return x86_isa_pkg::PFX_REPNE;
      2:       return x86_isa_pkg::PFX_ES;
      3:       return x86_isa_pkg::PFX_CS;
      4:       return x86_isa_pkg::PFX_SS;
      5:       return x86_isa_pkg::PFX_DS;
      6:       return x86_isa_pkg::PFX_FS;
      default: return x86_isa_pkg::PFX_GS;
    endcase
  endfunction

  // Mostly table opcodes, now and then any byte
  function automatic logic [7:0] pick_opcode(input int k);
    case (k)
      0:       return 8'h01;
      1:       return 8'h03;
      2:       return 8'h05;
      3:       return 8'h89;
      4:       return 8'h8B;
      5:       return 8'hB8 | 8'($urandom % 8);
      6:       return 8'hE9;
      7:       return 8'hEB;
      8:       return 8'h90;
      9:       return 8'hF4;
      default: return 8'($urandom);
    endcase
  endfunction

  // ModRM, SIB, displacement and immediate come from the random fill
  function automatic decode_pkg::fetch_bundle_t random_fetch();
    decode_pkg::fetch_bundle_t fb;
    int n_pfx;
    for (int i = 0; i < x86_isa_pkg::WINDOW_BYTES; i++) begin
      fb.window[i] = 8'($urandom);
    end
    fb.eip = $urandom;
    n_pfx  = $urandom % 5;
    for (int i = 0; i < n_pfx; i++) begin
      fb.window[i] = pick_prefix($urandom % 8);
    end
    fb.window[n_pfx] = pick_opcode($urandom % 12);
    // Stray prefix value right after the opcode
    if (($urandom % 4) == 0) begin
      fb.window[n_pfx + 1] = pick_prefix($urandom % 8);
    end
    return fb;
  endfunction

  task automatic show_diff(input string name, input logic [31:0] g, input logic [31:0] w);
    if (g != w) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, g, w);
    end
  endtask

  task automatic report_mismatch(input decode_pkg::decode_bundle_t g,
                                 input decode_pkg::decode_bundle_t w);
    show_diff("eip", g.eip, w.eip);
    show_diff("next_eip", g.next_eip, w.next_eip);
    show_diff("length", 32'(g.length), 32'(w.length));
    show_diff("prefix.count", 32'(g.prefix.count), 32'(w.prefix.count));
    show_diff("prefix.op_size_over", 32'(g.prefix.op_size_over), 32'(w.prefix.op_size_over));
    show_diff("prefix.repne", 32'(g.prefix.repne), 32'(w.prefix.repne));
    show_diff("prefix.seg_over", 32'(g.prefix.seg_over), 32'(w.prefix.seg_over));
    show_diff("prefix.seg", 32'(g.prefix.seg), 32'(w.prefix.seg));
    show_diff("op", 32'(g.op), 32'(w.op));
    show_diff("alu_op", 32'(g.alu_op), 32'(w.alu_op));
    show_diff("src1", 32'(g.src1), 32'(w.src1));
    show_diff("src1_needed", 32'(g.src1_needed), 32'(w.src1_needed));
    show_diff("src2", 32'(g.src2), 32'(w.src2));
    show_diff("src2_needed", 32'(g.src2_needed), 32'(w.src2_needed));
    show_diff("dst", 32'(g.dst), 32'(w.dst));
    show_diff("ld_reg", 32'(g.ld_reg), 32'(w.ld_reg));
    show_diff("mem_read", 32'(g.mem_read), 32'(w.mem_read));
    show_diff("mem_write", 32'(g.mem_write), 32'(w.mem_write));
    show_diff("scale", 32'(g.scale), 32'(w.scale));
    show_diff("index", 32'(g.index), 32'(w.index));
    show_diff("base", 32'(g.base), 32'(w.base));
    show_diff("sib_present", 32'(g.sib_present), 32'(w.sib_present));
    show_diff("disp32", g.disp32, w.disp32);
    show_diff("imm32", g.imm32, w.imm32);
    show_diff("ld_flags", 32'(g.ld_flags), 32'(w.ld_flags));
    show_diff("illegal", 32'(g.illegal), 32'(w.illegal));
  endtask

  // Scoreboard queue, head registered for the assertions
  always @(posedge clk) begin
    if (dec_valid && dec_ready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    if (fetch_valid && fetch_ready) begin
      exp_q.push_back(expected_bundle(fetch));
    end
    exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    exp_count <= exp_q.size();
    in_taken  <= fetch_valid && fetch_ready;
    if (dec_valid && dec_ready) begin
      n_out <= n_out + 1;
    end
  end

  out_pending: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid && dec_ready |-> exp_count > 0)
    else begin
      $display("TEST FAILED");
      $fatal(1, "Decoded bundle delivered with no instruction pending");
    end

  out_match: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid && dec_ready |-> dec == exp_head)
    else begin
      report_mismatch($sampled(dec), $sampled(exp_head));
      $display("TEST FAILED");
      $fatal(1, "Decoded bundle does not match the expected bundle");
    end

  initial begin
    #(NUM_INSTR * 40 * 20);
    $display("TEST FAILED");
    $fatal(1, "Timeout waiting for all decoded instructions");
  end

  initial begin
    void'($urandom(65346));
    rst_n       = 1'b0;
    fetch       = '0;
    fetch_valid = 1'b0;
    dec_ready   = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (n_out < NUM_INSTR) begin
      @(negedge clk);
      dec_ready = ($urandom % 4) != 0;
      // Hold the offered bundle until it is taken
      if (!fetch_valid || in_taken) begin
        if ((n_sent < NUM_INSTR) && (($urandom % 8) != 0)) begin
          fetch       = random_fetch();
          fetch_valid = 1'b1;
          n_sent++;
        end else begin
          fetch_valid = 1'b0;
        end
      end
    end
    fetch_valid = 1'b0;
    repeat (2) @(negedge clk);
    // Register must be empty once every instruction has left
    if (dec_valid) begin
      $display("TEST FAILED");
      $fatal(1, "Decoded output still valid after the last instruction left");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sources.f
source/x86_isa_pkg.sv
source/decode_pkg.sv
source/prefix_scanner.sv
source/opcode_rom.sv
source/modrm_decoder.sv
source/field_extractor.sv
source/decode_stage.sv
sim/decode_checker.sv
sim/tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f sources.f \
  --top-module tb_decode_stage \
  --Mdir obj_dir \
  -o tb_decode_stage
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit "$build_status"
fi

if [ ! -x ./obj_dir/tb_decode_stage ]; then
  echo "Simulation binary not found"
  exit 1
fi

./obj_dir/tb_decode_stage
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation ended with status $sim_status"
fi
exit "$sim_status"
